/* verilog/mips_pkg.sv */
// shared types and constants; memories are 64 words each and only the listed MIPS subset decodes
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  exc_code_t;

    localparam exc_code_t EXC_NONE       = 3'd0;
    localparam exc_code_t EXC_ILLEGAL    = 3'd1;
    localparam exc_code_t EXC_OVERFLOW   = 3'd2;
    localparam exc_code_t EXC_MISALIGN   = 3'd3;
    localparam exc_code_t EXC_WRITE_ZERO = 3'd7;

    // alu_op encodings
    localparam logic [1:0] ALU_ADDR  = 2'd0;   // address add without overflow check
    localparam logic [1:0] ALU_ADDI  = 2'd1;   // checked add
    localparam logic [1:0] ALU_FUNCT = 2'd2;   // r-type op picked by funct

    typedef struct packed {
        logic       reg_write;
        logic       dest_is_rd;
        logic       alu_src_imm;
        logic       mem_read;
        logic       mem_write;
        logic       mem_to_reg;
        logic       is_branch;
        logic       is_jump;
        logic [1:0] alu_op;
    } ctrl_t;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    localparam word_t RESET_PC = 32'h0040_0000;

    localparam int IMEM_WORDS = 64;
    localparam int IMEM_AW    = 6;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = 6;   // indexed by address bits 7:2

endpackage

/* verilog/register_file.sv */
// register zero reads as zero and ignores writes; a same-cycle write is seen by both read ports
`timescale 1ns/1ps

module register_file (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    input  logic                we,
    input  mips_pkg::reg_addr_t wr_reg,
    input  mips_pkg::word_t     wr_data
);
    import mips_pkg::*;

    word_t regs [32];

    assign rs_data = (rs == '0) ? '0 : (we && wr_reg == rs) ? wr_data : regs[rs];
    assign rt_data = (rt == '0) ? '0 : (we && wr_reg == rt) ? wr_data : regs[rt];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && wr_reg != '0)
        begin
            regs[wr_reg] <= wr_data;
        end
    end

endmodule

/* verilog/fetch_unit.sv */
// instruction memory is indexed by pc bits 7:2 only and is loaded through the program port
`timescale 1ns/1ps

module fetch_unit (
    input  logic                         SYS_clk,
    input  logic                         SYS_reset,
    input  logic                         stall,
    input  logic                         freeze,
    input  logic                         redirect,
    input  mips_pkg::word_t              redirect_pc,
    input  logic                         prog_we,
    input  logic [mips_pkg::IMEM_AW-1:0] prog_addr,
    input  mips_pkg::word_t              prog_data,
    output mips_pkg::word_t              d_instr,
    output mips_pkg::word_t              d_pc
);
    import mips_pkg::*;

    word_t pc;
    word_t imem [IMEM_WORDS];
    word_t f_instr;

    assign f_instr = imem[pc[IMEM_AW+1:2]];

    always_ff @(posedge SYS_clk)
    begin
        if (prog_we)
        begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc      <= RESET_PC;
            d_instr <= '0;
        end
        else if (freeze)
        begin
            d_instr <= '0;   // pc holds while frozen
        end
        else if (!stall)
        begin
            pc      <= redirect ? redirect_pc : pc + 32'd4;
            d_instr <= redirect ? '0 : f_instr;   // kill the wrong-path word
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
        begin
            d_pc <= pc;
        end
    end

endmodule

/* verilog/hazard_unit.sv */
// forwarding only from the memory stage; anything else in flight interlocks decode
`timescale 1ns/1ps

module hazard_unit (
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  logic                use_rs,
    input  logic                use_rt,
    input  mips_pkg::reg_addr_t ex_dest,
    input  logic                ex_writes,
    input  logic                ex_is_load,
    input  mips_pkg::reg_addr_t mem_dest,
    input  logic                mem_writes,
    input  logic                mem_is_load,
    output logic                stall,
    output logic                fwd_rs,
    output logic                fwd_rt
);
    logic ex_hit;
    logic mem_rs_hit;
    logic mem_rt_hit;
    logic ex_alu_stall;
    logic ex_load_stall;
    logic mem_load_stall;

    assign ex_hit = ex_writes && (ex_dest != '0)
                    && ((use_rs && ex_dest == rs) || (use_rt && ex_dest == rt));

    assign mem_rs_hit = mem_writes && use_rs && (mem_dest != '0) && (mem_dest == rs);
    assign mem_rt_hit = mem_writes && use_rt && (mem_dest != '0) && (mem_dest == rt);

    // alu producer waits one cycle, a load waits here and again in memory
    assign ex_alu_stall   = ex_hit && !ex_is_load;
    assign ex_load_stall  = ex_hit && ex_is_load;
    assign mem_load_stall = mem_is_load && (mem_rs_hit || mem_rt_hit);

    assign stall  = ex_alu_stall || ex_load_stall || mem_load_stall;
    assign fwd_rs = mem_rs_hit && !mem_is_load;
    assign fwd_rt = mem_rt_hit && !mem_is_load;

endmodule

/* verilog/decode_unit.sv */
// the all-zero word is treated as a bubble, not as sll; branches resolve here with no delay slot
`timescale 1ns/1ps

module decode_unit (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::word_t     d_instr,
    input  mips_pkg::word_t     d_pc,
    input  logic                stall,
    input  logic                freeze,
    input  logic                fwd_rs,
    input  logic                fwd_rt,
    input  mips_pkg::word_t     mem_fwd_data,
    input  logic                wb_we,
    input  mips_pkg::reg_addr_t wb_reg,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output logic                use_rs,
    output logic                use_rt,
    output logic                redirect,
    output mips_pkg::word_t     redirect_pc,
    output mips_pkg::ctrl_t     e_ctrl,
    output mips_pkg::word_t     e_a,
    output mips_pkg::word_t     e_b,
    output mips_pkg::word_t     e_imm,
    output mips_pkg::reg_addr_t e_dest,
    output mips_pkg::word_t     e_pc,
    output mips_pkg::exc_code_t e_cause
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    ctrl_t      ctrl;
    logic       illegal;
    logic       taken;
    word_t      rs_data;
    word_t      rt_data;
    word_t      op_a;
    word_t      op_b;
    word_t      imm;
    word_t      pc_plus4;

    assign opcode   = d_instr[31:26];
    assign funct    = d_instr[5:0];
    assign rs       = d_instr[25:21];
    assign rt       = d_instr[20:16];
    assign imm      = {{16{d_instr[15]}}, d_instr[15:0]};
    assign pc_plus4 = d_pc + 32'd4;

    always_comb
    begin
        ctrl    = '0;
        illegal = 1'b0;
        use_rs  = 1'b0;
        use_rt  = 1'b0;
        if (d_instr != '0)
        begin
            case (opcode)
                OP_RTYPE:
                begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.dest_is_rd = 1'b1;
                    ctrl.alu_op     = ALU_FUNCT;
                    use_rs          = 1'b1;
                    use_rt          = 1'b1;
                    illegal = !(funct inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT});
                end
                OP_ADDI:
                begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op      = ALU_ADDI;
                    use_rs           = 1'b1;
                end
                OP_LW:
                begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.mem_to_reg  = 1'b1;
                    use_rs           = 1'b1;
                end
                OP_SW:
                begin
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_write   = 1'b1;
                    use_rs           = 1'b1;
                    use_rt           = 1'b1;   // store data
                end
                OP_BEQ, OP_BNE:
                begin
                    ctrl.is_branch = 1'b1;
                    use_rs         = 1'b1;
                    use_rt         = 1'b1;
                end
                OP_J:    ctrl.is_jump = 1'b1;
                default: illegal = 1'b1;
            endcase
        end
    end

    register_file rf0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs        (rs),
        .rt        (rt),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .we        (wb_we),
        .wr_reg    (wb_reg),
        .wr_data   (wb_data)
    );

    assign op_a = fwd_rs ? mem_fwd_data : rs_data;
    assign op_b = fwd_rt ? mem_fwd_data : rt_data;

    // bne inverts the equality test
    assign taken       = ctrl.is_branch && ((op_a == op_b) != (opcode == OP_BNE));
    assign redirect    = !stall && (taken || ctrl.is_jump);
    assign redirect_pc = ctrl.is_jump ? {pc_plus4[31:28], d_instr[25:0], 2'b00}
                                      : pc_plus4 + (imm << 2);

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            e_ctrl  <= '0;
            e_cause <= EXC_NONE;
        end
        else if (stall || freeze)
        begin
            e_ctrl  <= '0;   // bubble into execute
            e_cause <= EXC_NONE;
        end
        else
        begin
            e_ctrl  <= illegal ? '0 : ctrl;
            e_cause <= illegal ? EXC_ILLEGAL : EXC_NONE;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        e_a    <= op_a;
        e_b    <= op_b;
        e_imm  <= imm;
        e_dest <= ctrl.dest_is_rd ? d_instr[15:11] : rt;
        e_pc   <= d_pc;
    end

endmodule

/* verilog/execute_unit.sv */
// overflow is checked for add, sub and addi only; load/store address adds wrap silently
`timescale 1ns/1ps

module execute_unit (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                freeze,
    input  mips_pkg::ctrl_t     e_ctrl,
    input  mips_pkg::word_t     e_a,
    input  mips_pkg::word_t     e_b,
    input  mips_pkg::word_t     e_imm,
    input  mips_pkg::reg_addr_t e_dest,
    input  mips_pkg::word_t     e_pc,
    input  mips_pkg::exc_code_t e_cause,
    output mips_pkg::reg_addr_t ex_dest,
    output logic                ex_writes,
    output logic                ex_is_load,
    output mips_pkg::ctrl_t     m_ctrl,
    output mips_pkg::word_t     m_alu,
    output mips_pkg::word_t     m_store_data,
    output mips_pkg::reg_addr_t m_dest,
    output mips_pkg::word_t     m_pc,
    output logic                m_misaligned,
    output mips_pkg::exc_code_t m_cause
);
    import mips_pkg::*;

    word_t     alu_b;
    word_t     sum;
    word_t     diff;
    word_t     result;
    logic      add_ovf;
    logic      sub_ovf;
    logic      ovf;
    exc_code_t cause;

    assign alu_b   = e_ctrl.alu_src_imm ? e_imm : e_b;
    assign sum     = e_a + alu_b;
    assign diff    = e_a - alu_b;
    assign add_ovf = (e_a[31] == alu_b[31]) && (sum[31] != e_a[31]);
    assign sub_ovf = (e_a[31] != alu_b[31]) && (diff[31] != e_a[31]);

    always_comb
    begin
        result = sum;
        ovf    = 1'b0;
        case (e_ctrl.alu_op)
            ALU_ADDI: ovf = add_ovf;
            ALU_FUNCT:
            begin
                case (e_imm[5:0])   // funct sits in the low immediate bits
                    FN_ADD: ovf = add_ovf;
                    FN_SUB:
                    begin
                        result = diff;
                        ovf    = sub_ovf;
                    end
                    FN_AND:  result = e_a & alu_b;
                    FN_OR:   result = e_a | alu_b;
                    FN_SLT:  result = {31'd0, $signed(e_a) < $signed(alu_b)};
                    default: result = sum;
                endcase
            end
            default: ovf = 1'b0;
        endcase
    end

    // an older cause from decode wins
    assign cause = (e_cause != EXC_NONE) ? e_cause : ovf ? EXC_OVERFLOW : EXC_NONE;

    assign ex_dest    = e_dest;
    assign ex_writes  = e_ctrl.reg_write;
    assign ex_is_load = e_ctrl.mem_read;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            m_ctrl  <= '0;
            m_cause <= EXC_NONE;
        end
        else if (freeze)
        begin
            m_ctrl  <= '0;
            m_cause <= EXC_NONE;
        end
        else
        begin
            m_ctrl  <= (cause != EXC_NONE) ? '0 : e_ctrl;   // faulting op goes on as a bubble
            m_cause <= cause;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        m_alu        <= result;
        m_store_data <= e_b;
        m_dest       <= e_dest;
        m_pc         <= e_pc;
        m_misaligned <= |result[1:0];
    end

endmodule

/* verilog/memory_unit.sv */
// data memory uses address bits 7:2 only, higher bits alias; stores are dropped while frozen
`timescale 1ns/1ps

module memory_unit (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                freeze,
    input  mips_pkg::ctrl_t     m_ctrl,
    input  mips_pkg::word_t     m_alu,
    input  mips_pkg::word_t     m_store_data,
    input  mips_pkg::reg_addr_t m_dest,
    input  mips_pkg::word_t     m_pc,
    input  logic                m_misaligned,
    input  mips_pkg::exc_code_t m_cause,
    output mips_pkg::reg_addr_t mem_dest,
    output logic                mem_writes,
    output logic                mem_is_load,
    output mips_pkg::word_t     mem_fwd_data,
    output logic                wb_we,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data,
    output mips_pkg::exc_code_t wb_cause,
    output mips_pkg::word_t     wb_pc
);
    import mips_pkg::*;

    word_t              dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] addr;
    logic               misalign;
    exc_code_t          cause;
    logic               w_reg_write;
    logic               w_mem_to_reg;
    exc_code_t          w_cause;
    word_t              w_load;
    word_t              w_alu;

    assign addr     = m_alu[DMEM_AW+1:2];
    assign misalign = (m_ctrl.mem_read || m_ctrl.mem_write) && m_misaligned;
    assign cause    = (m_cause != EXC_NONE) ? m_cause : misalign ? EXC_MISALIGN : EXC_NONE;

    assign mem_dest     = m_dest;
    assign mem_writes   = m_ctrl.reg_write;
    assign mem_is_load  = m_ctrl.mem_read;
    assign mem_fwd_data = m_alu;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
            begin
                dmem[i] <= '0;
            end
        end
        else if (m_ctrl.mem_write && cause == EXC_NONE && !freeze)
        begin
            dmem[addr] <= m_store_data;
        end
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            w_reg_write  <= 1'b0;
            w_mem_to_reg <= 1'b0;
            w_cause      <= EXC_NONE;
        end
        else if (freeze)
        begin
            w_reg_write  <= 1'b0;
            w_mem_to_reg <= 1'b0;
            w_cause      <= EXC_NONE;
        end
        else
        begin
            w_reg_write  <= m_ctrl.reg_write && cause == EXC_NONE;
            w_mem_to_reg <= m_ctrl.mem_to_reg;
            w_cause      <= cause;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        w_load <= dmem[addr];
        w_alu  <= m_alu;
        wb_reg <= m_dest;
        wb_pc  <= m_pc;
    end

    assign wb_data  = w_mem_to_reg ? w_load : w_alu;
    assign wb_cause = (w_cause != EXC_NONE) ? w_cause
                    : (w_reg_write && wb_reg == '0) ? EXC_WRITE_ZERO : EXC_NONE;
    assign wb_we    = w_reg_write && wb_cause == EXC_NONE;

endmodule

/* verilog/exception_ctrl.sv */
// first fault wins and is held until reset; there is no handler vector or restart
`timescale 1ns/1ps

module exception_ctrl (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::exc_code_t wb_cause,
    input  mips_pkg::word_t     wb_pc,
    output logic                freeze,
    output logic                halted,
    output mips_pkg::exc_code_t exc_cause,
    output mips_pkg::word_t     epc
);
    import mips_pkg::*;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            halted    <= 1'b0;
            exc_cause <= EXC_NONE;
            epc       <= '0;
        end
        else if (!halted && wb_cause != EXC_NONE)
        begin
            halted    <= 1'b1;
            exc_cause <= wb_cause;
            epc       <= wb_pc;
        end
    end

    // freeze starts in the faulting cycle so younger work is flushed at once
    assign freeze = halted || (wb_cause != EXC_NONE);

endmodule

/* verilog/mips_core.sv */
// load the program with prog_we while reset is held; after a fault the core stays halted
`timescale 1ns/1ps

module mips_core (
    input  logic                         SYS_clk,
    input  logic                         SYS_reset,
    input  logic                         prog_we,
    input  logic [mips_pkg::IMEM_AW-1:0] prog_addr,
    input  mips_pkg::word_t              prog_data,
    output logic                         commit_valid,
    output mips_pkg::reg_addr_t          commit_reg,
    output mips_pkg::word_t              commit_data,
    output logic                         halted,
    output mips_pkg::exc_code_t          exc_cause,
    output mips_pkg::word_t              epc
);
    import mips_pkg::*;

    word_t     d_instr;
    word_t     d_pc;
    logic      stall;
    logic      freeze;
    logic      redirect;
    word_t     redirect_pc;
    reg_addr_t rs;
    reg_addr_t rt;
    logic      use_rs;
    logic      use_rt;
    logic      fwd_rs;
    logic      fwd_rt;
    ctrl_t     e_ctrl;
    word_t     e_a;
    word_t     e_b;
    word_t     e_imm;
    reg_addr_t e_dest;
    word_t     e_pc;
    exc_code_t e_cause;
    reg_addr_t ex_dest;
    logic      ex_writes;
    logic      ex_is_load;
    ctrl_t     m_ctrl;
    word_t     m_alu;
    word_t     m_store_data;
    reg_addr_t m_dest;
    word_t     m_pc;
    logic      m_misaligned;
    exc_code_t m_cause;
    reg_addr_t mem_dest;
    logic      mem_writes;
    logic      mem_is_load;
    word_t     mem_fwd_data;
    logic      wb_we;
    reg_addr_t wb_reg;
    word_t     wb_data;
    exc_code_t wb_cause;
    word_t     wb_pc;

    // every register-file write is a commit
    assign commit_valid = wb_we;
    assign commit_reg   = wb_reg;
    assign commit_data  = wb_data;

    fetch_unit     fetch0 (.*);
    hazard_unit    hazard0 (.*);
    decode_unit    decode0 (.*);
    execute_unit   execute0 (.*);
    memory_unit    memory0 (.*);
    exception_ctrl exc0 (.*);

endmodule

/* sim/mips_assertions.sv */
// checks are disabled while reset is high; bound into every mips_core instance
`timescale 1ns/1ps

module mips_assertions (
    input logic                SYS_clk,
    input logic                SYS_reset,
    input logic                commit_valid,
    input mips_pkg::reg_addr_t commit_reg,
    input logic                halted,
    input mips_pkg::exc_code_t exc_cause
);
    import mips_pkg::*;

    commit_not_r0: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        commit_valid |-> commit_reg != '0)
        else $error("commit to register zero");

    quiet_when_halted: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        halted |-> !commit_valid)
        else $error("commit while halted");

    halt_is_sticky: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        halted |=> halted)
        else $error("halted dropped without reset");

    halt_has_cause: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        halted |-> exc_cause != EXC_NONE)
        else $error("halted with no exception cause");

endmodule

bind mips_core mips_assertions chk0 (
    .SYS_clk      (SYS_clk),
    .SYS_reset    (SYS_reset),
    .commit_valid (commit_valid),
    .commit_reg   (commit_reg),
    .halted       (halted),
    .exc_cause    (exc_cause)
);

/* sim/mips_ref.svh */
// included inside mips_tb; programs fill at most 64 words, branch only forward and end in one fault
`ifndef MIPS_REF_SVH
`define MIPS_REF_SVH

function automatic word_t rtype_word(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                     logic [5:0] fn);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t itype_word(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic reg_addr_t pick_reg();
    return reg_addr_t'(1 + $urandom % 7);   // r1..r7 keeps dependencies dense
endfunction

function automatic logic [5:0] pick_funct();
    case ($urandom % 5)
        0:       return FN_ADD;
        1:       return FN_SUB;
        2:       return FN_AND;
        3:       return FN_OR;
        default: return FN_SLT;
    endcase
endfunction

function automatic logic signed_ovf(word_t x, word_t y, logic sub);
    logic [32:0] wide;
    wide = sub ? ({x[31], x} - {y[31], y}) : ({x[31], x} + {y[31], y});
    return wide[32] != wide[31];   // sign bits disagree after extension
endfunction

// random body of n words, then the tail for the chosen fault starting at word n
function automatic void build_program(int fault);
    int n;
    int off;
    n = 24 + int'($urandom % 8);
    for (int i = 0; i < IMEM_WORDS; i++)
    begin
        prog[i] = '0;
    end
    for (int i = 0; i < n; i++)
    begin
        off = int'($urandom % 3);
        if (off > n - i - 1)
        begin
            off = n - i - 1;   // never past the first tail word
        end
        case ($urandom % 10)
            0, 1, 2, 3: prog[i] = rtype_word(pick_reg(), pick_reg(), pick_reg(), pick_funct());
            4, 5: prog[i] = itype_word(OP_ADDI, pick_reg(), pick_reg(),
                                       16'(($urandom % 4096) - 2048));
            6: prog[i] = itype_word(OP_LW, 5'd0, pick_reg(), 16'(4 * ($urandom % 8)));
            7: prog[i] = itype_word(OP_SW, 5'd0, pick_reg(), 16'(4 * ($urandom % 8)));
            8: prog[i] = itype_word(($urandom % 2 == 0) ? OP_BEQ : OP_BNE,
                                    pick_reg(), pick_reg(), 16'(off));
            default: prog[i] = {OP_J, RESET_PC[27:2] + 26'(i + 1 + off)};
        endcase
    end
    case (fault)
        0: prog[n] = {6'h3f, 26'($urandom)};   // unused opcode
        1:
        begin
            prog[n] = itype_word(OP_ADDI, 5'd0, 5'd8, 16'h7fff);
            for (int k = 1; k <= 17; k++)
            begin
                prog[n + k] = rtype_word(5'd8, 5'd8, 5'd8, FN_ADD);   // 17th doubling overflows
            end
        end
        2: prog[n] = itype_word(OP_LW, 5'd0, pick_reg(),
                                16'(4 * ($urandom % 8) + 1 + $urandom % 3));
        default: prog[n] = itype_word(OP_ADDI, pick_reg(), 5'd0, 16'($urandom % 256));
    endcase
endfunction

// ISA interpreter stepping one instruction at a time in program order
function automatic void run_model();
    word_t     regs [32];
    word_t     dmem [DMEM_WORDS];
    word_t     ins;
    word_t     a;
    word_t     b;
    word_t     imm;
    word_t     res;
    reg_addr_t dest;
    exc_code_t cause;
    logic      wr;
    int        idx;
    int        here;
    regs = '{default: '0};
    dmem = '{default: '0};
    exp_reg.delete();
    exp_data.delete();
    exp_cause = EXC_NONE;
    exp_epc   = '0;
    idx       = 0;
    while (idx < IMEM_WORDS && exp_cause == EXC_NONE)
    begin
        here  = idx;
        ins   = prog[idx];
        a     = regs[ins[25:21]];
        b     = regs[ins[20:16]];
        imm   = {{16{ins[15]}}, ins[15:0]};
        res   = a + imm;   // addi sum or load/store address
        dest  = ins[20:16];
        wr    = 1'b0;
        cause = EXC_NONE;
        idx   = idx + 1;
        case (ins[31:26])
            OP_RTYPE:
            begin
                dest = ins[15:11];
                wr   = 1'b1;
                case (ins[5:0])
                    FN_ADD:
                    begin
                        res   = a + b;
                        cause = signed_ovf(a, b, 1'b0) ? EXC_OVERFLOW : EXC_NONE;
                    end
                    FN_SUB:
                    begin
                        res   = a - b;
                        cause = signed_ovf(a, b, 1'b1) ? EXC_OVERFLOW : EXC_NONE;
                    end
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: cause = EXC_ILLEGAL;
                endcase
            end
            OP_ADDI:
            begin
                wr    = 1'b1;
                cause = signed_ovf(a, imm, 1'b0) ? EXC_OVERFLOW : EXC_NONE;
            end
            OP_LW:
            begin
                wr = 1'b1;
                if (res[1:0] != 2'b00)
                    cause = EXC_MISALIGN;
                else
                    res = dmem[res[7:2]];
            end
            OP_SW:
            begin
                if (res[1:0] != 2'b00)
                    cause = EXC_MISALIGN;
                else
                    dmem[res[7:2]] = b;
            end
            OP_BEQ:  if (a == b) idx = idx + int'($signed(ins[15:0]));
            OP_BNE:  if (a != b) idx = idx + int'($signed(ins[15:0]));
            OP_J:    idx = int'(ins[25:0]) - int'(RESET_PC[27:2]);
            default: cause = EXC_ILLEGAL;
        endcase
        if (cause == EXC_NONE && wr && dest == '0)
            cause = EXC_WRITE_ZERO;
        if (cause != EXC_NONE)
        begin
            exp_cause = cause;
            exp_epc   = RESET_PC + 32'(4 * here);
        end
        else if (wr)
        begin
            regs[dest] = res;
            exp_reg.push_back(dest);
            exp_data.push_back(res);
        end
    end
endfunction

`endif

/* sim/mips_tb.sv */
// runs four random programs, each ending in a different fault; a program is loaded under reset
`timescale 1ns/1ps

module mips_tb;
    import mips_pkg::*;

    localparam int TIMEOUT_CYCLES = 4 * (64 * 3 + 20);

    logic               SYS_clk;
    logic               SYS_reset;
    logic               prog_we;
    logic [IMEM_AW-1:0] prog_addr;
    word_t              prog_data;
    logic               commit_valid;
    reg_addr_t          commit_reg;
    word_t              commit_data;
    logic               halted;
    exc_code_t          exc_cause;
    word_t              epc;

    word_t     prog [IMEM_WORDS];
    reg_addr_t exp_reg [$];
    word_t     exp_data [$];
    exc_code_t exp_cause;
    word_t     exp_epc;
    int        commit_errs = 0;
    int        fault_errs  = 0;
    int        reset_errs  = 0;
    int        commits_seen = 0;
    int        run_cycles  = 0;

    `include "mips_ref.svh"

    mips_core dut0 (.*);

    initial
    begin
        SYS_clk = 1'b0;
        forever #5 SYS_clk = ~SYS_clk;
    end

    always @(posedge SYS_clk)
    begin
        if (!SYS_reset)
            run_cycles <= run_cycles + 1;
    end

    initial
    begin
        wait (run_cycles >= TIMEOUT_CYCLES);
        $display("timeout: the core did not halt within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    // outputs only move on the rising edge, so the falling edge sees them settled
    always @(negedge SYS_clk)
    begin
        if (!SYS_reset && commit_valid === 1'b1)
        begin
            commits_seen = commits_seen + 1;
            if (exp_reg.size() == 0)
            begin
                $display("commit to r%0d arrived with no write left in the model", commit_reg);
                commit_errs = commit_errs + 1;
            end
            else
            begin
                if (commit_reg !== exp_reg[0])
                begin
                    $display("[ERROR] commit_reg = %h, expected %h", commit_reg, exp_reg[0]);
                    commit_errs = commit_errs + 1;
                end
                if (commit_data !== exp_data[0])
                begin
                    $display("[ERROR] commit_data = %h, expected %h", commit_data, exp_data[0]);
                    commit_errs = commit_errs + 1;
                end
                void'(exp_reg.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    task automatic check_idle(string when);
        if (commit_valid !== 1'b0)
        begin
            $display("[ERROR] %s: commit_valid = %h, expected 0", when, commit_valid);
            reset_errs++;
        end
        if (halted !== 1'b0)
        begin
            $display("[ERROR] %s: halted = %h, expected 0", when, halted);
            reset_errs++;
        end
        if (epc !== '0)
        begin
            $display("[ERROR] %s: epc = %h, expected 0", when, epc);
            reset_errs++;
        end
    endtask

    task automatic load_and_reset();
        SYS_reset = 1'b1;
        for (int i = 0; i < IMEM_WORDS; i++)
        begin
            prog_we   = 1'b1;
            prog_addr = IMEM_AW'(i);
            prog_data = prog[i];
            @(negedge SYS_clk);
        end
        prog_we = 1'b0;
        repeat (5)
        begin
            check_idle("in reset");
            @(negedge SYS_clk);
        end
        SYS_reset = 1'b0;
        @(negedge SYS_clk);
        check_idle("after reset");
    endtask

    task automatic check_outcome(int test);
        if (exc_cause !== exp_cause)
        begin
            $display("[ERROR] test %0d: exc_cause = %h, expected %h", test, exc_cause, exp_cause);
            fault_errs++;
        end
        if (epc !== exp_epc)
        begin
            $display("[ERROR] test %0d: epc = %h, expected %h", test, epc, exp_epc);
            fault_errs++;
        end
        if (exp_reg.size() != 0)
        begin
            $display("test %0d: %0d expected register writes never committed", test,
                     exp_reg.size());
            commit_errs++;
        end
    endtask

    initial
    begin
        void'($urandom(32'h3196_01a2));
        SYS_reset = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        for (int t = 0; t < 4; t++)
        begin
            build_program(t);   // 0 illegal, 1 overflow, 2 misaligned, 3 write to r0
            run_model();
            load_and_reset();
            while (halted !== 1'b1)
                @(negedge SYS_clk);
            repeat (4) @(negedge SYS_clk);   // no commit may follow the fault
            check_outcome(t);
        end
        $display("errors: commit %0d, fault %0d, reset %0d; %0d commits checked",
                 commit_errs, fault_errs, reset_errs, commits_seen);
        if (commit_errs + fault_errs + reset_errs == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+sim
verilog/mips_pkg.sv
verilog/register_file.sv
verilog/fetch_unit.sv
verilog/hazard_unit.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/memory_unit.sv
verilog/exception_ctrl.sv
verilog/mips_core.sv
sim/mips_assertions.sv
sim/mips_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build the core and testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module mips_tb -f filelist.f --Mdir obj_dir
	@out="$$(./obj_dir/Vmips_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
